/* rtl/burstCollect.sv */
// Assembles one line from a burst of read words; datRead is only valid while ack is high
`include "sdramTiming_defines.svh"

module burstCollect (
    input  logic          Clock,
    input  logic          rstN,
    input  logic          wordValid,
    input  logic          writeDone,
    input  hostPkg::wordT dqIn,
    output logic          ack,
    output logic          done,
    output hostPkg::lineT datRead
);

    localparam int WORD_W = $bits(hostPkg::wordT);
    localparam int LINE_W = $bits(hostPkg::lineT);
    localparam hostPkg::wordIdxT LAST_WORD = hostPkg::wordIdxT'(`SDRAM_BURST - 1);

    hostPkg::wordIdxT wordCnt;
    logic             lastWord;

    assign lastWord = wordValid && (wordCnt == LAST_WORD);

    // ----------------------------------------
    // Word counter and completion pulse
    // ----------------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            wordCnt <= '0;
            ack     <= 1'b0;
        end else begin
            if (wordValid) wordCnt <= wordCnt + 1'b1;   // Wraps to 0 after the eighth word
            ack <= lastWord || writeDone;               // Single-cycle pulse
        end
    end

    assign done = ack;   // Frees the decoder in the same cycle the master sees ack

    // Shift right so the first word ends in the low 16 bits
    always_ff @(posedge Clock) begin
        if (wordValid) datRead <= {dqIn, datRead[LINE_W-1:WORD_W]};
    end

endmodule

/* rtl/hostDecode.sv */
// Captures one Wishbone classic request at a time; the master must hold it until ack
module hostDecode (
    input  logic              Clock,
    input  logic              rstN,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  hostPkg::lineAddrT adr,
    input  hostPkg::lineT     datWrite,
    input  logic              done,
    input  logic              reqTaken,
    input  hostPkg::wordIdxT  wordIdx,
    output logic              reqValid,
    output logic              reqWrite,
    output hostPkg::bankT     bank,
    output hostPkg::rowT      row,
    output hostPkg::colT      col,
    output hostPkg::wordT     writeWord
);

    logic              busy;       // Set from capture until completion
    logic              capture;
    hostPkg::lineAddrT adrReg;
    hostPkg::lineT     lineReg;

    assign capture = cyc && stb && !busy;

    // Request flags
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            reqValid <= 1'b0;
            busy     <= 1'b0;
        end else if (capture) begin
            reqValid <= 1'b1;
            busy     <= 1'b1;
        end else begin
            if (reqTaken) reqValid <= 1'b0;   // Sequencer has issued ACTIVE
            if (done)     busy     <= 1'b0;   // Ack is on the bus this cycle
        end
    end

    // Captured payload, stable until the next capture
    always_ff @(posedge Clock) begin
        if (capture) begin
            reqWrite <= we;
            adrReg   <= adr;
            lineReg  <= datWrite;
        end
    end

    // Line address split
    assign bank = adrReg[21:20];
    assign row  = adrReg[19:7];
    assign col  = {adrReg[6:0], 3'b000};

    // Word select for the write burst
    assign writeWord = lineReg[wordIdx * $bits(hostPkg::wordT) +: $bits(hostPkg::wordT)];

endmodule

/* rtl/hostPkg.sv */
// Host-side types for 128-bit lines on a 22-bit line address, 4 banks x 8K rows x 1K columns
package hostPkg;

    typedef logic [127:0] lineT;       // One Wishbone line, word 0 in the low bits
    typedef logic [15:0]  wordT;       // One SDRAM data word
    typedef logic [21:0]  lineAddrT;   // Bank 21:20, row 19:7, line in row 6:0

    // Fields handed to the sequencer
    typedef logic [1:0]   bankT;
    typedef logic [12:0]  rowT;
    typedef logic [9:0]   colT;        // Line number with three zero bits below
    typedef logic [2:0]   wordIdxT;    // Word position inside a burst

endpackage

/* rtl/sdramCmdPkg.sv */
// Device-side encodings; mode word is fixed to burst 8, sequential, CAS 2
package sdramCmdPkg;

    // Bits are the RAS, CAS and WE pin levels (CS held low outside)
    typedef enum logic [2:0] {
        CMD_LOAD_MODE = 3'b000,
        CMD_REFRESH   = 3'b001,
        CMD_PRECHARGE = 3'b010,
        CMD_ACTIVE    = 3'b011,
        CMD_WRITE     = 3'b100,
        CMD_READ      = 3'b101,
        CMD_NOP       = 3'b111     // 3'b110 is burst stop, never issued
    } sdramCmdT;

    // Sequencer states, init chain first
    typedef enum logic [3:0] {
        S_RESET,
        S_INIT_WAIT,
        S_INIT_PRECHARGE,
        S_INIT_REFRESH,
        S_INIT_MODE,
        S_IDLE,
        S_ACTIVATE,
        S_READ,
        S_WRITE,
        S_PRECHARGE,
        S_REFRESH
    } seqStateT;

    // Reserved 000, programmed write burst, op 00, CAS 010, sequential, BL 011
    localparam logic [12:0] modeWord = 13'b000_0_00_010_0_011;

endpackage

/* rtl/sdramSequencer.sv */
// Closes the row after every access; CAS latency must be 2 or 3 and INIT_NOPS below 65536
`include "sdramTiming_defines.svh"

module sdramSequencer (
    input  logic             Clock,
    input  logic             rstN,
    input  logic             reqValid,
    input  logic             reqWrite,
    input  hostPkg::bankT    bank,
    input  hostPkg::rowT     row,
    input  hostPkg::colT     col,
    input  hostPkg::wordT    writeWord,
    output logic             reqTaken,
    output logic             wordValid,
    output logic             writeDone,
    output hostPkg::wordIdxT wordIdx,
    output logic [12:0]      sdramAddr,
    output hostPkg::bankT    sdramBa,
    output logic             sdramCsN,
    output logic             sdramRasN,
    output logic             sdramCasN,
    output logic             sdramWeN,
    output logic             sdramCke,
    output logic [1:0]       sdramDqm,
    output hostPkg::wordT    dqOut,
    output logic             dqOe
);

    // Last count value of each timed state
    localparam logic [15:0] LAST_INIT  = 16'(`SDRAM_INIT_NOPS - 1);
    localparam logic [15:0] LAST_TRP   = 16'(`SDRAM_TRP - 1);
    localparam logic [15:0] LAST_TRCD  = 16'(`SDRAM_TRCD - 1);
    localparam logic [15:0] LAST_TRC   = 16'(`SDRAM_TRC - 1);
    localparam logic [15:0] LAST_TMRD  = 16'(`SDRAM_TMRD - 1);
    localparam logic [15:0] LAST_BURST = 16'(`SDRAM_BURST - 1);
    localparam logic [15:0] LAST_WRITE = 16'(`SDRAM_BURST);         // One write recovery cycle
    localparam logic [3:0]  LAST_IREF  = 4'(`SDRAM_INIT_REFRESHES - 1);
    localparam int          REF_W      = $clog2(`SDRAM_REFRESH_INTERVAL + 1);
    localparam logic [REF_W-1:0] REF_DUE =
        REF_W'(`SDRAM_REFRESH_INTERVAL - `SDRAM_REFRESH_MARGIN);

    sdramCmdPkg::seqStateT state, stateNext;
    sdramCmdPkg::sdramCmdT cmd;
    logic [15:0]           cnt, cntNext;          // Shared per-state cycle counter
    logic [3:0]            initRefCnt, initRefNext;
    logic [REF_W-1:0]      refCnt;
    logic                  refreshDue;
    logic                  inInit;
    logic                  readSlot;
    logic [`SDRAM_CAS-1:0] rdPipe;

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state      <= sdramCmdPkg::S_RESET;
            cnt        <= '0;
            initRefCnt <= '0;
            refCnt     <= '0;
            rdPipe     <= '0;
        end else begin
            state      <= stateNext;
            cnt        <= cntNext;
            initRefCnt <= initRefNext;
            rdPipe     <= {rdPipe[`SDRAM_CAS-2:0], readSlot};
            // Held at zero until the init refreshes start, restarted by every refresh
            if (state inside {sdramCmdPkg::S_INIT_WAIT, sdramCmdPkg::S_INIT_PRECHARGE} ||
                cmd == sdramCmdPkg::CMD_REFRESH)
                refCnt <= '0;
            else
                refCnt <= refCnt + 1'b1;
        end
    end

    assign refreshDue = (refCnt >= REF_DUE);

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_comb begin
        stateNext   = state;
        cntNext     = cnt + 16'd1;
        initRefNext = initRefCnt;
        cmd         = sdramCmdPkg::CMD_NOP;
        sdramAddr   = '0;
        sdramBa     = '0;
        case (state)
            sdramCmdPkg::S_RESET: begin
                stateNext = sdramCmdPkg::S_INIT_WAIT;
                cntNext   = '0;
            end
            sdramCmdPkg::S_INIT_WAIT: begin
                if (cnt == LAST_INIT) begin
                    stateNext = sdramCmdPkg::S_INIT_PRECHARGE;
                    cntNext   = '0;
                end
            end
            sdramCmdPkg::S_INIT_PRECHARGE: begin
                if (cnt == '0) begin
                    cmd           = sdramCmdPkg::CMD_PRECHARGE;
                    sdramAddr[10] = 1'b1;                   // A10 high selects all banks
                end
                if (cnt == LAST_TRP) begin
                    stateNext = sdramCmdPkg::S_INIT_REFRESH;
                    cntNext   = '0;
                end
            end
            sdramCmdPkg::S_INIT_REFRESH: begin
                if (cnt == '0) cmd = sdramCmdPkg::CMD_REFRESH;
                if (cnt == LAST_TRC) begin
                    cntNext     = '0;
                    initRefNext = initRefCnt + 4'd1;
                    if (initRefCnt == LAST_IREF) stateNext = sdramCmdPkg::S_INIT_MODE;
                end
            end
            sdramCmdPkg::S_INIT_MODE: begin
                if (cnt == '0) begin
                    cmd       = sdramCmdPkg::CMD_LOAD_MODE;
                    sdramAddr = sdramCmdPkg::modeWord;
                end
                if (cnt == LAST_TMRD) begin
                    stateNext = sdramCmdPkg::S_IDLE;
                    cntNext   = '0;
                end
            end
            sdramCmdPkg::S_IDLE: begin
                cntNext = '0;
                if (refreshDue)    stateNext = sdramCmdPkg::S_REFRESH;   // Refresh wins
                else if (reqValid) stateNext = sdramCmdPkg::S_ACTIVATE;
            end
            sdramCmdPkg::S_ACTIVATE: begin
                if (cnt == '0) begin
                    cmd       = sdramCmdPkg::CMD_ACTIVE;
                    sdramAddr = row;
                    sdramBa   = bank;
                end
                if (cnt == LAST_TRCD) begin
                    stateNext = reqWrite ? sdramCmdPkg::S_WRITE : sdramCmdPkg::S_READ;
                    cntNext   = '0;
                end
            end
            sdramCmdPkg::S_READ: begin
                if (cnt == '0) begin
                    cmd       = sdramCmdPkg::CMD_READ;
                    sdramAddr = {3'b000, col};               // A10 low, no auto-precharge
                    sdramBa   = bank;
                end
                if (cnt == LAST_BURST) begin
                    stateNext = sdramCmdPkg::S_PRECHARGE;
                    cntNext   = '0;
                end
            end
            sdramCmdPkg::S_WRITE: begin
                if (cnt == '0) begin
                    cmd       = sdramCmdPkg::CMD_WRITE;
                    sdramAddr = {3'b000, col};
                    sdramBa   = bank;
                end
                if (cnt == LAST_WRITE) begin
                    stateNext = sdramCmdPkg::S_PRECHARGE;
                    cntNext   = '0;
                end
            end
            sdramCmdPkg::S_PRECHARGE: begin
                if (cnt == '0) begin
                    cmd     = sdramCmdPkg::CMD_PRECHARGE;    // Single bank, A10 low
                    sdramBa = bank;
                end
                if (cnt == LAST_TRP) begin
                    stateNext = sdramCmdPkg::S_IDLE;
                    cntNext   = '0;
                end
            end
            sdramCmdPkg::S_REFRESH: begin
                if (cnt == '0) cmd = sdramCmdPkg::CMD_REFRESH;
                if (cnt == LAST_TRC) begin
                    stateNext = sdramCmdPkg::S_IDLE;
                    cntNext   = '0;
                end
            end
            default: begin
                stateNext = sdramCmdPkg::S_IDLE;
                cntNext   = '0;
            end
        endcase
    end

    // ----------------------------------------
    // Handshakes and data path
    // ----------------------------------------
    assign reqTaken  = (state == sdramCmdPkg::S_ACTIVATE) && (cnt == '0);
    assign writeDone = (state == sdramCmdPkg::S_WRITE) && (cnt == LAST_BURST);
    assign readSlot  = (state == sdramCmdPkg::S_READ);     // Device clocks out one word
    assign wordValid = rdPipe[`SDRAM_CAS-1];               // Word lands CAS cycles later

    // Word 0 goes out with the WRITE command
    assign wordIdx = hostPkg::wordIdxT'(cnt);
    assign dqOut   = writeWord;
    assign dqOe    = (state == sdramCmdPkg::S_WRITE) && (cnt <= LAST_BURST);

    // Pins
    assign {sdramRasN, sdramCasN, sdramWeN} = cmd;
    assign sdramCsN = 1'b0;
    assign sdramCke = 1'b1;                                 // No power-down
    assign inInit   = state inside {sdramCmdPkg::S_RESET, sdramCmdPkg::S_INIT_WAIT,
                                    sdramCmdPkg::S_INIT_PRECHARGE,
                                    sdramCmdPkg::S_INIT_REFRESH, sdramCmdPkg::S_INIT_MODE};
    assign sdramDqm = inInit ? 2'b11 : 2'b00;               // Masked until init ends

endmodule

/* rtl/sdramTiming_defines.svh */
// SDRAM timing in clock cycles; INIT_NOPS and REFRESH_INTERVAL are sized for simulation only
`ifndef SDRAM_TIMING_DEFINES_SVH
`define SDRAM_TIMING_DEFINES_SVH

// ----------------------------------------
// Power-up sequence
// ----------------------------------------
`define SDRAM_INIT_NOPS         20      // NOP cycles after reset, 100 us on real silicon
`define SDRAM_INIT_REFRESHES    8       // Auto-refreshes before the mode load

// ----------------------------------------
// Command spacing
// ----------------------------------------
`define SDRAM_TRP               2       // Precharge to next command
`define SDRAM_TRCD              2       // Activate to read or write
`define SDRAM_TRC               7       // Refresh to next command
`define SDRAM_TMRD              2       // Mode load to next command

// Burst geometry
`define SDRAM_CAS               2       // Read latency, matches the mode word
`define SDRAM_BURST             8       // 16-bit words per 128-bit line

// Refresh scheduling
`define SDRAM_REFRESH_INTERVAL  200     // Longest gap between auto-refreshes
`define SDRAM_REFRESH_MARGIN    24      // Early start so a full access still fits

`endif

/* rtl/sdramTop.sv */
// SDRAM controller top; the DQ tristate buffer lives in a board wrapper outside this design
module sdramTop (
    input  logic              Clock,
    input  logic              rstN,
    // Wishbone classic slave
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  hostPkg::lineAddrT adr,
    input  hostPkg::lineT     datWrite,
    output hostPkg::lineT     datRead,
    output logic              ack,
    // SDRAM pins
    output logic [12:0]       sdramAddr,
    output hostPkg::bankT     sdramBa,
    output logic              sdramCsN,
    output logic              sdramRasN,
    output logic              sdramCasN,
    output logic              sdramWeN,
    output logic              sdramCke,
    output logic [1:0]        sdramDqm,
    output hostPkg::wordT     dqOut,
    output logic              dqOe,
    input  hostPkg::wordT     dqIn
);

    // ----------------------------------------
    // Internal handshake
    // ----------------------------------------
    logic             reqValid;
    logic             reqWrite;
    logic             reqTaken;
    logic             wordValid;
    logic             writeDone;
    logic             done;
    hostPkg::bankT    bank;
    hostPkg::rowT     row;
    hostPkg::colT     col;
    hostPkg::wordT    writeWord;
    hostPkg::wordIdxT wordIdx;

    hostDecode uDecode (
        .Clock(Clock), .rstN(rstN),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWrite(datWrite),
        .done(done), .reqTaken(reqTaken), .wordIdx(wordIdx),
        .reqValid(reqValid), .reqWrite(reqWrite),
        .bank(bank), .row(row), .col(col), .writeWord(writeWord)
    );

    sdramSequencer uSeq (
        .Clock(Clock), .rstN(rstN),
        .reqValid(reqValid), .reqWrite(reqWrite),
        .bank(bank), .row(row), .col(col), .writeWord(writeWord),
        .reqTaken(reqTaken), .wordValid(wordValid), .writeDone(writeDone),
        .wordIdx(wordIdx),
        .sdramAddr(sdramAddr), .sdramBa(sdramBa), .sdramCsN(sdramCsN),
        .sdramRasN(sdramRasN), .sdramCasN(sdramCasN), .sdramWeN(sdramWeN),
        .sdramCke(sdramCke), .sdramDqm(sdramDqm),
        .dqOut(dqOut), .dqOe(dqOe)
    );

    burstCollect uCollect (
        .Clock(Clock), .rstN(rstN),
        .wordValid(wordValid), .writeDone(writeDone), .dqIn(dqIn),
        .ack(ack), .done(done), .datRead(datRead)
    );

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and exit non-zero unless the run passes
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module sdramTb -Mdir obj_dir -f sdramSys.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOut=$(./obj_dir/VsdramTb 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -q "Simulation PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

/* sdramSys.f */
+incdir+rtl
rtl/sdramCmdPkg.sv
rtl/hostPkg.sv
rtl/hostDecode.sv
rtl/sdramSequencer.sv
rtl/burstCollect.sv
rtl/sdramTop.sv
tests/sdramModel.sv
tests/sdramTb.sv

/* tests/sdramModel.sv */
// Behavioral SDRAM for simulation; bursts of 8, CAS from the defines, unwritten words read as zero
`include "sdramTiming_defines.svh"

module sdramModel (
    input  logic              Clock,
    input  logic [12:0]       sdramAddr,
    input  hostPkg::bankT     sdramBa,
    input  logic              sdramCsN,
    input  logic              sdramRasN,
    input  logic              sdramCasN,
    input  logic              sdramWeN,
    input  logic              sdramCke,
    input  logic [1:0]        sdramDqm,
    input  hostPkg::wordT     dqOut,
    input  logic              dqOe,
    output hostPkg::wordT     dqIn,
    input  hostPkg::lineAddrT hostAdr,     // Request held by the master, for the decode check
    output logic              initDone,
    output int                refreshCount,
    output logic              errFlag
);
    timeunit 1ns;
    timeprecision 100ps;

    // BL 8, sequential, CAS 2, written from the datasheet field layout
    localparam logic [12:0] MODE_EXPECT = 13'b000_0_00_010_0_011;

    hostPkg::wordT         mem [logic [24:0]];     // Key is bank, row, column
    logic [12:0]           openRow [4];
    sdramCmdPkg::sdramCmdT cmd;
    sdramCmdPkg::sdramCmdT lastCmd = sdramCmdPkg::CMD_NOP;
    int                    cycleNum = 0;
    int                    lastCmdCycle = -100;
    int                    lastRefresh = 0;
    int                    initRefreshes = 0;
    int                    postRefreshes = 0;
    int                    readWait = 0;
    int                    readLeft = 0;
    int                    writeLeft = 0;
    logic [24:0]           readKey = '0;
    logic [24:0]           writeKey = '0;
    logic                  prechargedAll = 1'b0;
    logic                  modeSeen = 1'b0;
    logic                  errSeen = 1'b0;
    hostPkg::wordT         readWord = '0;

    assign dqIn         = readWord;
    assign initDone     = modeSeen;
    assign refreshCount = postRefreshes;
    assign errFlag      = errSeen;

    task automatic flagError(input string msg);
        $display("SDRAM model error at %0t ns: %s", $time, msg);
        errSeen = 1'b1;
    endtask

    // Minimum cycles from the previous command to this one
    function automatic int gapNeeded(input sdramCmdPkg::sdramCmdT prev,
                                     input sdramCmdPkg::sdramCmdT now);
        case (prev)
            sdramCmdPkg::CMD_PRECHARGE: return `SDRAM_TRP;
            sdramCmdPkg::CMD_REFRESH:   return `SDRAM_TRC;
            sdramCmdPkg::CMD_LOAD_MODE: return `SDRAM_TMRD;
            sdramCmdPkg::CMD_ACTIVE:
                return (now inside {sdramCmdPkg::CMD_READ, sdramCmdPkg::CMD_WRITE}) ?
                       `SDRAM_TRCD : 1;
            default:                    return 1;
        endcase
    endfunction

    always @(posedge Clock) begin
        cycleNum = cycleNum + 1;
        cmd      = sdramCmdPkg::sdramCmdT'({sdramRasN, sdramCasN, sdramWeN});
        if (sdramCsN || !sdramCke) flagError("chip deselected or clock disabled");
        if (!modeSeen && sdramDqm !== 2'b11)
            flagError("data mask released before initialization finished");

        // ----------------------------------------
        // Read data, driven one edge before the CAS edge
        // ----------------------------------------
        if (readWait > 0) begin
            readWait = readWait - 1;
        end else if (readLeft > 0) begin
            readWord <= mem.exists(readKey) ? mem[readKey] : '0;
            readKey  = readKey + 25'd1;
            readLeft = readLeft - 1;
        end

        if (modeSeen && (cycleNum - lastRefresh > `SDRAM_REFRESH_INTERVAL))
            flagError("no auto-refresh within the refresh interval");

        // ----------------------------------------
        // Command decode
        // ----------------------------------------
        if (cmd != sdramCmdPkg::CMD_NOP) begin
            if (cycleNum - lastCmdCycle < gapNeeded(lastCmd, cmd))
                flagError("command issued before the previous one's minimum gap");
            case (cmd)
                sdramCmdPkg::CMD_PRECHARGE: begin
                    if (!modeSeen && sdramAddr[10]) prechargedAll = 1'b1;
                end
                sdramCmdPkg::CMD_REFRESH: begin
                    if (modeSeen) postRefreshes = postRefreshes + 1;
                    else if (prechargedAll) initRefreshes = initRefreshes + 1;
                    lastRefresh = cycleNum;
                end
                sdramCmdPkg::CMD_LOAD_MODE: begin
                    if (sdramAddr !== MODE_EXPECT) flagError("wrong mode register value");
                    if (!prechargedAll || initRefreshes < `SDRAM_INIT_REFRESHES)
                        flagError("mode load before precharge-all and the init refreshes");
                    modeSeen = 1'b1;
                end
                sdramCmdPkg::CMD_ACTIVE: begin
                    if (!modeSeen) flagError("ACTIVE before initialization finished");
                    if (sdramBa !== hostAdr[21:20] || sdramAddr !== hostAdr[19:7])
                        flagError("bank or row at ACTIVE does not match the host address");
                    openRow[sdramBa] = sdramAddr;
                end
                sdramCmdPkg::CMD_READ, sdramCmdPkg::CMD_WRITE: begin
                    if (sdramBa !== hostAdr[21:20] ||
                        sdramAddr !== {3'b000, hostAdr[6:0], 3'b000})
                        flagError("column at READ or WRITE does not match the host address");
                    if (cmd == sdramCmdPkg::CMD_READ) begin
                        readKey  = {sdramBa, openRow[sdramBa], sdramAddr[9:0]};
                        readWait = `SDRAM_CAS - 2;
                        readLeft = `SDRAM_BURST;
                    end else begin
                        writeKey  = {sdramBa, openRow[sdramBa], sdramAddr[9:0]};
                        writeLeft = `SDRAM_BURST;
                    end
                end
                default: flagError("unsupported command on the bus");
            endcase
            lastCmd      = cmd;
            lastCmdCycle = cycleNum;
        end

        // Write data, first word on the WRITE edge
        if (writeLeft > 0) begin
            if (!dqOe || sdramDqm != 2'b00) flagError("write word not driven or masked");
            mem[writeKey] = dqOut;
            writeKey  = writeKey + 25'd1;
            writeLeft = writeLeft - 1;
        end else if (dqOe) begin
            flagError("data bus driven outside a write burst");
        end
    end

endmodule

/* tests/sdramTb.sv */
// Random Wishbone line traffic from LFSR seed 55, checked against a sparse reference memory
`include "sdramTiming_defines.svh"

module sdramTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OPS      = 300;
    localparam int POOL_SIZE    = 16;       // Small address pool so reads hit written lines
    localparam int ACCESS_WORST = 48;       // Capture, refresh, access, precharge, ack, stall
    localparam int INIT_CYCLES  = 4 + `SDRAM_INIT_NOPS + `SDRAM_TRP +
                                  `SDRAM_INIT_REFRESHES * `SDRAM_TRC + `SDRAM_TMRD + 10;
    localparam int TIMEOUT_NS   = 4 * (INIT_CYCLES + (NUM_OPS + 2) * ACCESS_WORST);

    logic              Clock = 1'b0;
    logic              rstN;
    logic              cyc;
    logic              stb;
    logic              we;
    hostPkg::lineAddrT adr;
    hostPkg::lineT     datWrite;
    hostPkg::lineT     datRead;
    logic              ack;
    logic [12:0]       sdramAddr;
    hostPkg::bankT     sdramBa;
    logic              sdramCsN;
    logic              sdramRasN;
    logic              sdramCasN;
    logic              sdramWeN;
    logic              sdramCke;
    logic [1:0]        sdramDqm;
    hostPkg::wordT     dqOut;
    logic              dqOe;
    hostPkg::wordT     dqIn;
    logic              initDone;
    int                refreshCount;
    logic              modelErr;

    logic [31:0]       lfsrState = 32'd55;
    hostPkg::lineT     refMem [hostPkg::lineAddrT];   // Lines written so far
    hostPkg::lineAddrT pool [POOL_SIZE];

    always #2 Clock = ~Clock;                          // 4 ns period

    sdramTop DUT (
        .Clock(Clock), .rstN(rstN),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWrite(datWrite),
        .datRead(datRead), .ack(ack),
        .sdramAddr(sdramAddr), .sdramBa(sdramBa), .sdramCsN(sdramCsN),
        .sdramRasN(sdramRasN), .sdramCasN(sdramCasN), .sdramWeN(sdramWeN),
        .sdramCke(sdramCke), .sdramDqm(sdramDqm),
        .dqOut(dqOut), .dqOe(dqOe), .dqIn(dqIn)
    );

    sdramModel memModel (
        .Clock(Clock),
        .sdramAddr(sdramAddr), .sdramBa(sdramBa), .sdramCsN(sdramCsN),
        .sdramRasN(sdramRasN), .sdramCasN(sdramCasN), .sdramWeN(sdramWeN),
        .sdramCke(sdramCke), .sdramDqm(sdramDqm),
        .dqOut(dqOut), .dqOe(dqOe), .dqIn(dqIn),
        .hostAdr(adr), .initDone(initDone), .refreshCount(refreshCount),
        .errFlag(modelErr)
    );

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    // Galois LFSR, taps 32 22 2 1
    function automatic logic nextBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) lfsrState = lfsrState ^ 32'h8020_0003;
        return outBit;
    endfunction

    function automatic logic [127:0] randomBits(input int n);
        logic [127:0] value;
        value = '0;
        for (int i = 0; i < n; i++) value = {value[126:0], nextBit()};
        return value;
    endfunction

    task automatic checkValue(input string testName, input logic [127:0] expected,
                              input logic [127:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", testName, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // One Wishbone classic cycle, called and returning on a falling edge
    task automatic doAccess(input string testName, input logic isWrite,
                            input hostPkg::lineAddrT a, input hostPkg::lineT line);
        hostPkg::lineT expected;
        int            stall;
        cyc      = 1'b1;
        stb      = 1'b1;
        we       = isWrite;
        adr      = a;
        datWrite = line;
        @(negedge Clock);
        while (!ack) @(negedge Clock);                  // Watchdog covers a lost ack
        checkValue("ack after mode load", 128'(1'b1), 128'(initDone));
        if (isWrite) begin
            refMem[a] = line;
        end else begin
            expected = refMem.exists(a) ? refMem[a] : '0;
            checkValue(testName, expected, datRead);
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(negedge Clock);
        checkValue("single-cycle ack", '0, 128'(ack));
        stall = int'(randomBits(2));                    // Random master stall
        repeat (stall) begin
            @(negedge Clock);
            checkValue("no ack between requests", '0, 128'(ack));
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        hostPkg::lineAddrT a;
        hostPkg::lineT     line;
        logic              isWrite;
        rstN     = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        datWrite = '0;
        repeat (4) @(negedge Clock);
        rstN = 1'b1;
        for (int i = 0; i < POOL_SIZE; i++) pool[i] = hostPkg::lineAddrT'(randomBits(22));

        // Same line written and read back, word order included
        line = randomBits(128);
        doAccess("write line", 1'b1, pool[0], line);
        doAccess("read back line", 1'b0, pool[0], line);

        for (int i = 0; i < NUM_OPS; i++) begin
            isWrite = nextBit();
            if (3'(randomBits(3)) == 3'd0)
                a = hostPkg::lineAddrT'(randomBits(22));    // Mostly never written
            else
                a = pool[4'(randomBits(4))];
            line = randomBits(128);
            doAccess(isWrite ? "random write" : "random read", isWrite, a, line);
        end
        checkValue("refreshes after init", 128'(1'b1), 128'(refreshCount > 0));

        if (modelErr) begin
            $display("Simulation FAILED");
            $fatal(1, "SDRAM model flagged a bus violation");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    // Model violations stop the run on the next falling edge
    always @(negedge Clock) begin
        if (modelErr) begin
            $display("Simulation FAILED");
            $fatal(1, "SDRAM model flagged a bus violation");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the controller stopped answering requests");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
